/* source/encoderPkg.sv */
`default_nettype none

package encoderPkg;

	////////////////////////////////////////////////////////////////////////////
	// Datapath widths
	////////////////////////////////////////////////////////////////////////////

	localparam int sampleW = 16;	// Speech sample
	localparam int corrW = 32;	// Stored autocorrelation result
	localparam int accW = 40;	// MAC accumulator, 80 full-scale squares fit

	////////////////////////////////////////////////////////////////////////////
	// Frame defaults
	////////////////////////////////////////////////////////////////////////////

	localparam int defFrameLen = 80;
	localparam int defOrder = 10;
	localparam int defOutAddrW = 4;	// Must address Order+1 results

	// Sequencer stages, in frame order
	typedef enum logic [1:0]
	{
		stIdle,
		stLoad,
		stAutocorr
	} stageT;

endpackage

`default_nettype wire

/* source/encoderIfs.sv */
`default_nettype none

// Stage control between the sequencer and one processing unit
interface stageCtrlIf;
	import encoderPkg::*;

	stageT stage;
	logic request;	// Stage entered
	logic go;	// Gate released
	logic finish;	// Unit done with its stage

	modport seq
	(
		output stage,
		output request,
		output go,
		input finish
	);

	modport unit
	(
		input stage,
		input go,
		output finish
	);
endinterface

// Two read ports into the frame store, one per lag operand
interface sampleRdIf #(parameter int FrameLen = encoderPkg::defFrameLen);
	import encoderPkg::*;

	localparam int AddrW = $clog2(FrameLen);

	logic [AddrW-1:0] addrA;
	logic [AddrW-1:0] addrB;
	logic signed [sampleW-1:0] dataA;
	logic signed [sampleW-1:0] dataB;

	modport reader(output addrA, output addrB, input dataA, input dataB);
	modport store(input addrA, input addrB, output dataA, output dataB);
endinterface

`default_nettype wire

/* source/sampleBuffer.sv */
`default_nettype none

module sampleBuffer #(
	parameter int FrameLen = encoderPkg::defFrameLen
)(
	input logic clock,
	input logic rstN,
	input logic [encoderPkg::sampleW-1:0] in,
	stageCtrlIf.unit ctrl,
	sampleRdIf.store rd
);
	import encoderPkg::*;

	localparam int AddrW = $clog2(FrameLen);

	logic signed [sampleW-1:0] mem [FrameLen];
	logic [AddrW-1:0] wrIdx;
	logic writing;
	logic finishQ;
	logic loadGo;
	logic wrEn;
	logic [AddrW-1:0] wrAddr;

	assign loadGo = ctrl.go && (ctrl.stage == stLoad);
	assign wrEn = loadGo || writing;
	assign wrAddr = writing ? wrIdx : '0;	// Sample 0 lands on the go edge

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			writing <= 1'b0;
			wrIdx <= '0;
			finishQ <= 1'b0;
		end
		else
		begin
			finishQ <= 1'b0;
			if (loadGo)
			begin
				writing <= 1'b1;
				wrIdx <= AddrW'(1);
			end
			else if (writing)
			begin
				if (wrIdx == AddrW'(FrameLen - 1))
				begin
					writing <= 1'b0;
					finishQ <= 1'b1;
				end
				else
					wrIdx <= wrIdx + 1'b1;
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (wrEn)
			mem[wrAddr] <= in;
	end

	// Lag operand reads
	assign rd.dataA = mem[rd.addrA];
	assign rd.dataB = mem[rd.addrB];

	assign ctrl.finish = finishQ && (ctrl.stage == stLoad);

	wrIdxBound: assert property (@(posedge clock) disable iff (!rstN)
		wrIdx <= AddrW'(FrameLen - 1));

endmodule

`default_nettype wire

/* source/autocorrUnit.sv */
`default_nettype none

module autocorrUnit #(
	parameter int FrameLen = encoderPkg::defFrameLen,
	parameter int Order = encoderPkg::defOrder,
	parameter int OutAddrW = encoderPkg::defOutAddrW
)(
	input logic clock,
	input logic rstN,
	stageCtrlIf.unit ctrl,
	sampleRdIf.reader rd,
	input logic [OutAddrW-1:0] outBufAddr,
	output logic [encoderPkg::corrW-1:0] out
);
	import encoderPkg::*;

	localparam int AddrW = $clog2(FrameLen);
	localparam int LagW = $clog2(Order + 1);

	typedef enum logic
	{
		acIdle,
		acBusy
	} acStateT;

	acStateT state;
	logic [AddrW-1:0] n;
	logic [LagW-1:0] lag;
	logic signed [accW-1:0] acc;
	logic signed [accW-1:0] accNext;
	logic signed [2*sampleW-1:0] product;
	logic finishQ;
	logic corrGo;
	logic lastN;
	logic signed [corrW-1:0] resMem [Order+1];

	// Clamp to signed 32 bits
	function automatic logic signed [corrW-1:0] saturate(input logic signed [accW-1:0] v);
		if (v[accW-1:corrW-1] == {(accW-corrW+1){v[accW-1]}})
			return v[corrW-1:0];
		else if (v[accW-1])
			return {1'b1, {(corrW-1){1'b0}}};
		else
			return {1'b0, {(corrW-1){1'b1}}};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// MAC datapath, one product per cycle
	////////////////////////////////////////////////////////////////////////////

	assign rd.addrA = n;
	assign rd.addrB = n - AddrW'(lag);	// x[n-lag]

	assign product = rd.dataA * rd.dataB;
	assign accNext = acc + {{(accW-2*sampleW){product[2*sampleW-1]}}, product};

	assign corrGo = ctrl.go && (ctrl.stage == stAutocorr);
	assign lastN = (n == AddrW'(FrameLen - 1));

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			state <= acIdle;
			n <= '0;
			lag <= '0;
			acc <= '0;
			finishQ <= 1'b0;
			for (int i = 0; i <= Order; i++)
				resMem[i] <= '0;
		end
		else
		begin
			finishQ <= 1'b0;
			case (state)
				acIdle:
				begin
					if (corrGo)
					begin
						state <= acBusy;
						n <= '0;
						lag <= '0;
						acc <= '0;
					end
				end
				acBusy:
				begin
					if (lastN)
					begin
						resMem[lag] <= saturate(accNext);
						acc <= '0;
						if (lag == LagW'(Order))
						begin
							state <= acIdle;
							finishQ <= 1'b1;
						end
						else
						begin
							lag <= lag + 1'b1;
							n <= AddrW'(lag) + 1'b1;	// Next lag starts at n = lag
						end
					end
					else
					begin
						acc <= accNext;
						n <= n + 1'b1;
					end
				end
				default: state <= acIdle;
			endcase
		end
	end

	// Registered result read
	always_ff @(posedge clock)
		out <= (outBufAddr <= OutAddrW'(Order)) ? resMem[outBufAddr] : '0;

	assign ctrl.finish = finishQ && (ctrl.stage == stAutocorr);

	lagBound: assert property (@(posedge clock) disable iff (!rstN)
		(state == acBusy) |-> (lag <= LagW'(Order)));

endmodule

`default_nettype wire

/* source/frameSequencer.sv */
`default_nettype none

module frameSequencer (
	input logic clock,
	input logic rstN,
	input logic start,
	input logic testdone,
	stageCtrlIf.seq ctrl
);
	import encoderPkg::*;

	logic pending;	// Stage waiting on the host

	////////////////////////////////////////////////////////////////////////////
	// Stage FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			ctrl.stage <= stIdle;
			ctrl.request <= 1'b0;
		end
		else
		begin
			ctrl.request <= 1'b0;
			case (ctrl.stage)
				stIdle:
				begin
					if (start)
					begin
						ctrl.stage <= stLoad;
						ctrl.request <= 1'b1;
					end
				end
				stLoad:
				begin
					if (ctrl.finish)
					begin
						ctrl.stage <= stAutocorr;
						ctrl.request <= 1'b1;
					end
				end
				stAutocorr:
				begin
					if (ctrl.finish)
						ctrl.stage <= stIdle;	// Frame complete
				end
				default: ctrl.stage <= stIdle;
			endcase
		end
	end

	// Single-step gate, early testdone is dropped
	always_ff @(posedge clock)
	begin
		if (!rstN)
		begin
			pending <= 1'b0;
			ctrl.go <= 1'b0;
		end
		else
		begin
			ctrl.go <= 1'b0;
			if (ctrl.request)
				pending <= 1'b1;
			else if (pending && testdone)
			begin
				pending <= 1'b0;
				ctrl.go <= 1'b1;
			end
		end
	end

	goNeedsPending: assert property (@(posedge clock) disable iff (!rstN)
		ctrl.go |-> ($past(pending) && ctrl.stage != stIdle));

	requestGoApart: assert property (@(posedge clock) disable iff (!rstN)
		!(ctrl.request && ctrl.go));

endmodule

`default_nettype wire

/* source/encoderTop.sv */
`default_nettype none

module encoderTop #(
	parameter int FrameLen = encoderPkg::defFrameLen,
	parameter int Order = encoderPkg::defOrder,
	parameter int OutAddrW = encoderPkg::defOutAddrW
)(
	input logic clock,
	input logic rstN,
	input logic start,
	input logic [encoderPkg::sampleW-1:0] in,
	input logic testdone,
	input logic [OutAddrW-1:0] outBufAddr,
	output logic [encoderPkg::corrW-1:0] out,
	output logic done
);

	stageCtrlIf seqCtrl();
	stageCtrlIf loadCtrl();	// Sample load unit
	stageCtrlIf corrCtrl();	// Autocorrelation unit
	sampleRdIf #(.FrameLen(FrameLen)) sampleRd();

	// Fan stage and go out to both units
	assign loadCtrl.stage = seqCtrl.stage;
	assign loadCtrl.go = seqCtrl.go;
	assign corrCtrl.stage = seqCtrl.stage;
	assign corrCtrl.go = seqCtrl.go;

	assign seqCtrl.finish = loadCtrl.finish | corrCtrl.finish;

	frameSequencer iSeq (
		.clock(clock),
		.rstN(rstN),
		.start(start),
		.testdone(testdone),
		.ctrl(seqCtrl)
	);

	sampleBuffer #(.FrameLen(FrameLen)) iBuf (
		.clock(clock),
		.rstN(rstN),
		.in(in),
		.ctrl(loadCtrl),
		.rd(sampleRd)
	);

	autocorrUnit #(.FrameLen(FrameLen), .Order(Order), .OutAddrW(OutAddrW)) iCorr (
		.clock(clock),
		.rstN(rstN),
		.ctrl(corrCtrl),
		.rd(sampleRd),
		.outBufAddr(outBufAddr),
		.out(out)
	);

	// One pulse per finished stage
	always_ff @(posedge clock)
	begin
		if (!rstN)
			done <= 1'b0;
		else
			done <= seqCtrl.finish;
	end

endmodule

`default_nettype wire

/* test/tbEncoder.sv */
`default_nettype none

module tbEncoder;
	timeunit 1ns;
	timeprecision 100ps;

	import encoderPkg::*;

	localparam int FrameLen = defFrameLen;
	localparam int Order = defOrder;
	localparam int CorrLimit = 3000;	// Cycles allowed for the autocorrelation stage

	logic clock;
	logic rstN;
	logic start;
	logic testdone;
	logic [sampleW-1:0] in;
	logic [defOutAddrW-1:0] outBufAddr;
	logic [corrW-1:0] out;
	logic done;

	logic [31:0] rngState = 32'h93ce7a99;
	logic signed [sampleW-1:0] frame [FrameLen];
	int doneCount = 0;
	int frameBase = 0;
	int errors = 0;
	int testErrors = 0;
	int testsRun = 0;
	int testsFailed = 0;
	bit timedOut = 0;

	encoderTop uut (
		.clock(clock),
		.rstN(rstN),
		.start(start),
		.in(in),
		.testdone(testdone),
		.outBufAddr(outBufAddr),
		.out(out),
		.done(done)
	);

	initial
	begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(negedge clock)
	begin
		if (done)
			doneCount++;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Model of r[lag] clamped to signed 32 bits
	function automatic logic [corrW-1:0] refCorr(input int lag);
		longint sum;
		sum = 0;
		for (int n = lag; n < FrameLen; n++)
			sum += longint'(frame[n]) * longint'(frame[n - lag]);
		if (sum > 64'sd2147483647)
			return 32'h7fffffff;
		else if (sum < -64'sd2147483648)
			return 32'h80000000;
		return sum[31:0];
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
		begin
			$display("Error at time %0t: %s is %0d, expected %0d", $time, what,
				$signed(got), $signed(exp));
			errors++;
		end
	endtask

	// Each call ends 2 ns after a rising edge
	task automatic tick(input int cycles);
		repeat (cycles)
		begin
			@(posedge clock);
			#2;
		end
	endtask

	task automatic readResult(input int addr, output logic [corrW-1:0] value);
		outBufAddr = addr[defOutAddrW-1:0];
		tick(1);
		value = out;
	endtask

	task automatic waitDones(input int target, input int limit);
		int cycles;
		cycles = 0;
		if (timedOut)
			return;
		while (doneCount < target && cycles < limit)
		begin
			tick(1);
			cycles++;
		end
		if (doneCount < target)
		begin
			$display("Timeout: done pulse %0d did not arrive within %0d cycles", target, limit);
			timedOut = 1;
		end
	endtask

	task automatic fillRandom();
		for (int k = 0; k < FrameLen; k++)
		begin
			rngState = xorshift(rngState);
			frame[k] = {{3{rngState[12]}}, rngState[12:0]};	// 13-bit amplitude
		end
	endtask

	task automatic releaseStage();
		testdone = 1'b1;
		tick(1);
		testdone = 1'b0;
	endtask

	task automatic startFrame();
		start = 1'b1;
		tick(1);
		start = 1'b0;
		tick(1);	// Gate goes pending after the load request
	endtask

	// Go lands on the next edge and sample 0 one edge later
	task automatic loadFrame();
		releaseStage();
		for (int k = 0; k < FrameLen; k++)
		begin
			in = frame[k];
			tick(1);
		end
	endtask

	task automatic runFrame(input bit midStart, output int pulses);
		int base;
		base = doneCount;
		startFrame();
		loadFrame();
		waitDones(base + 1, 200);
		releaseStage();
		if (midStart)
		begin
			start = 1'b1;	// Dropped while the sequencer is busy
			tick(1);
			start = 1'b0;
		end
		waitDones(base + 2, CorrLimit);
		tick(3);
		pulses = doneCount - base;
	endtask

	task automatic checkResults(input string tag);
		logic [corrW-1:0] value;
		for (int a = 0; a <= Order + 1; a++)
		begin
			readResult(a, value);
			check($sformatf("%s r%0d", tag, a), value, (a <= Order) ? refCorr(a) : 32'h0);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic resetState();
		logic [corrW-1:0] value;
		for (int a = 0; a < (1 << defOutAddrW); a++)
		begin
			readResult(a, value);
			check($sformatf("out at address %0d after reset", a), value, 32'h0);
		end
		check("done pulses after reset", doneCount, 0);
	endtask

	task automatic gateHold();
		fillRandom();
		frameBase = doneCount;
		startFrame();
		tick(50);
		check("done pulses with testdone low", doneCount - frameBase, 0);
		loadFrame();
		waitDones(frameBase + 1, 200);
		tick(5);
		check("done pulses after load release", doneCount - frameBase, 1);
	endtask

	task automatic fullFrame();
		releaseStage();
		waitDones(frameBase + 2, CorrLimit);
		if (timedOut)
			return;
		checkResults("random");
	endtask

	task automatic saturation();
		int pulses;
		logic [corrW-1:0] value;
		for (int k = 0; k < FrameLen; k++)
			frame[k] = 16'sh7fff;
		runFrame(0, pulses);
		check("done pulses in saturated frame", pulses, 2);
		if (timedOut)
			return;
		for (int a = 0; a <= Order; a++)
		begin
			readResult(a, value);
			check($sformatf("saturated r%0d", a), value, 32'h7fffffff);
		end
	endtask

	task automatic backToBack();
		int pulses;
		fillRandom();
		runFrame(1, pulses);
		check("done pulses in frame A", pulses, 2);
		if (timedOut)
			return;
		checkResults("frame A");
		fillRandom();
		runFrame(0, pulses);
		check("done pulses in frame B", pulses, 2);
		if (timedOut)
			return;
		checkResults("frame B");
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (errors != testErrors || timedOut)
		begin
			testsFailed++;
			$display("%s: failed with %0d errors", name, errors - testErrors);
		end
		else
			$display("%s: passed", name);
	endtask

	initial
	begin
		string name;
		rstN = 1'b0;
		start = 1'b0;
		testdone = 1'b0;
		in = '0;
		outBufAddr = '0;
		tick(2);
		rstN = 1'b1;

		for (int t = 0; t < 5 && !timedOut; t++)
		begin
			testErrors = errors;
			case (t)
				0:
				begin
					name = "reset state";
					resetState();
				end
				1:
				begin
					name = "single-step gate";
					gateHold();
				end
				2:
				begin
					name = "full frame";
					fullFrame();
				end
				3:
				begin
					name = "saturation";
					saturation();
				end
				default:
				begin
					name = "back-to-back frames";
					backToBack();
				end
			endcase
			finishTest(name);
		end

		$display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
		if (errors == 0 && testsFailed == 0 && !timedOut)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
source/encoderPkg.sv
source/encoderIfs.sv
source/sampleBuffer.sv
source/autocorrUnit.sv
source/frameSequencer.sv
source/encoderTop.sv
test/tbEncoder.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the encoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	-f list.f --top-module tbEncoder -o simEncoder; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/simEncoder)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qxF "** PASS **" <<< "$output"; then
	exit 0
fi
exit 1
